//--- hw/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// byte address width
`define CACHE_ADDR_W    32

// data word width
`define CACHE_WORD_W    32

// word select within a block, 8 words per block
`define CACHE_OFFSET_W  3

// set index, 64 sets
`define CACHE_INDEX_W   6

// whatever is left above offset, index and the 2 byte bits
`define CACHE_TAG_W     (`CACHE_ADDR_W - `CACHE_OFFSET_W - `CACHE_INDEX_W - 2)

// ways per set
`define CACHE_WAYS      2

`endif

//--- hw/cache_line_pkg.sv
`include "cache_defines.svh"

package cache_line_pkg;

    ///////////////////////////////////////////////////////////////////////
    // address fields
    ///////////////////////////////////////////////////////////////////////

    typedef logic [`CACHE_TAG_W-1:0]    tag_t;
    typedef logic [`CACHE_INDEX_W-1:0]  index_t;
    typedef logic [`CACHE_OFFSET_W-1:0] word_sel_t;

    ///////////////////////////////////////////////////////////////////////
    // stored data
    ///////////////////////////////////////////////////////////////////////

    typedef logic [`CACHE_WORD_W-1:0]                      word_t;
    // full line, word 0 in the low bits
    typedef logic [(`CACHE_WORD_W << `CACHE_OFFSET_W)-1:0] block_t;
    typedef logic [`CACHE_WORD_W/8-1:0]                    byte_en_t;
    typedef logic [$clog2(`CACHE_WAYS)-1:0]                way_t;

    // per-line state kept next to the data
    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } line_meta_t;

endpackage

//--- hw/cache_bus_pkg.sv
`include "cache_defines.svh"

package cache_bus_pkg;

    ///////////////////////////////////////////////////////////////////////
    // processor side
    ///////////////////////////////////////////////////////////////////////

    // sampled while cpu_ready and cpu_req are both high
    typedef struct packed {
        logic                      write;
        logic [`CACHE_ADDR_W-1:0]  addr;
        cache_line_pkg::word_t     wdata;
        cache_line_pkg::byte_en_t  byte_en;
    } cpu_req_t;

    // read data, good only while cpu_done is high
    typedef struct packed {
        cache_line_pkg::word_t rdata;
    } cpu_rsp_t;

    ///////////////////////////////////////////////////////////////////////
    // memory side
    ///////////////////////////////////////////////////////////////////////

    // block address is tag plus index, wblock only used on a write
    typedef struct packed {
        logic                    write;
        cache_line_pkg::tag_t    tag;
        cache_line_pkg::index_t  index;
        cache_line_pkg::block_t  wblock;
    } mem_req_t;

    // controller sequence
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        FILL
    } ctrl_state_e;

endpackage

//--- hw/cache_way.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_way (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       en,
    input  logic                       lookup,
    input  logic                       wr_word,
    input  logic                       fill,
    input  cache_line_pkg::tag_t       tag,
    input  cache_line_pkg::index_t     index,
    input  cache_line_pkg::word_sel_t  word_sel,
    input  cache_line_pkg::byte_en_t   byte_en,
    input  cache_line_pkg::word_t      wdata,
    input  cache_line_pkg::block_t     fill_block,
    output logic                       hit,
    output cache_line_pkg::line_meta_t meta,
    output cache_line_pkg::word_t      rd_word,
    output cache_line_pkg::block_t     rd_block
);
    import cache_line_pkg::*;

    localparam int SETS  = 1 << `CACHE_INDEX_W;
    localparam int BYTES = `CACHE_WORD_W / 8;

    // valid and dirty per set, cleared on reset
    logic [SETS-1:0] valid_q;
    logic [SETS-1:0] dirty_q;

    // tag and data storage
    tag_t   tag_mem  [SETS];
    block_t data_mem [SETS];

    word_t merged;
    logic  word_we;
    logic  fill_we;

    ///////////////////////////////////////////////////////////////////////
    // read side, purely combinational on index
    ///////////////////////////////////////////////////////////////////////

    assign meta.valid = valid_q[index];
    assign meta.dirty = dirty_q[index];
    assign meta.tag   = tag_mem[index];

    assign rd_block = data_mem[index];
    assign rd_word  = rd_block[word_sel*`CACHE_WORD_W +: `CACHE_WORD_W];

    // compare only when enabled in lookup mode
    assign hit = en & lookup & meta.valid & (meta.tag == tag);

    // write strobes
    assign word_we = en & lookup & wr_word & hit;
    assign fill_we = en & fill;

    // byte merge of new data into the stored word
    always_comb begin
        merged = rd_word;
        for (int b = 0; b < BYTES; b++) begin
            if (byte_en[b]) begin
                merged[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // write side
    ///////////////////////////////////////////////////////////////////////

    // fill wins over word write, the controller never asks for both
    always_ff @(posedge clk) begin
        if (fill_we) begin
            data_mem[index] <= fill_block;
            tag_mem[index]  <= tag;
        end else if (word_we) begin
            data_mem[index][word_sel*`CACHE_WORD_W +: `CACHE_WORD_W] <= merged;
        end
    end

    // fresh line is clean, a word write dirties it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_we) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= 1'b0;
        end else if (word_we) begin
            dirty_q[index] <= 1'b1;
        end
    end

endmodule

//--- hw/victim_sel.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module victim_sel (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cache_line_pkg::index_t index,
    input  logic                   valid0,
    input  logic                   valid1,
    input  logic                   touch,
    input  cache_line_pkg::way_t   touch_way,
    output cache_line_pkg::way_t   victim
);

    localparam int SETS = 1 << `CACHE_INDEX_W;

    // one bit per set, names the least recently used way
    logic [SETS-1:0] lru_q;

    logic [`CACHE_WAYS-1:0] valid_vec;

    assign valid_vec = {valid1, valid0};

    // empty way first, way 0 ahead of way 1
    always_comb begin
        if (!valid_vec[0]) begin
            victim = 1'b0;
        end else if (!valid_vec[1]) begin
            victim = 1'b1;
        end else begin
            victim = lru_q[index];
        end
    end

    // way just used becomes most recent, so the other one is next out
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lru_q <= '0;
        end else if (touch) begin
            lru_q[index] <= ~touch_way;
        end
    end

endmodule

//--- hw/cache_set_assoc.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_set_assoc (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      lookup,
    input  logic                      wr_word,
    input  logic                      fill,
    input  cache_line_pkg::tag_t      tag,
    input  cache_line_pkg::index_t    index,
    input  cache_line_pkg::word_sel_t word_sel,
    input  cache_line_pkg::byte_en_t  byte_en,
    input  cache_line_pkg::word_t     wdata,
    input  cache_line_pkg::block_t    fill_block,
    output logic                      hit,
    output cache_line_pkg::way_t      hit_way,
    output logic                      victim_dirty,
    output logic                      victim_valid,
    output cache_line_pkg::word_t     rd_word,
    output cache_line_pkg::block_t    wb_block,
    output cache_line_pkg::tag_t      wb_tag
);
    import cache_line_pkg::*;

    // per-way control
    logic [`CACHE_WAYS-1:0] way_en;
    logic [`CACHE_WAYS-1:0] way_wr;
    logic [`CACHE_WAYS-1:0] way_fill;

    // per-way results
    logic [`CACHE_WAYS-1:0] way_hit;
    line_meta_t             way_meta  [`CACHE_WAYS];
    word_t                  way_word  [`CACHE_WAYS];
    block_t                 way_block [`CACHE_WAYS];

    way_t victim;

    ///////////////////////////////////////////////////////////////////////
    // way arrays
    ///////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < `CACHE_WAYS; k++) begin : g_way
        // lookup enables every way, a fill only the victim
        assign way_fill[k] = fill & (victim == way_t'(k));
        assign way_en[k]   = lookup | way_fill[k];
        // word write only lands in the way that hit
        assign way_wr[k]   = wr_word & way_hit[k];

        cache_way u_way (
            .clk        (clk),
            .rst_n      (rst_n),
            .en         (way_en[k]),
            .lookup     (lookup),
            .wr_word    (way_wr[k]),
            .fill       (way_fill[k]),
            .tag        (tag),
            .index      (index),
            .word_sel   (word_sel),
            .byte_en    (byte_en),
            .wdata      (wdata),
            .fill_block (fill_block),
            .hit        (way_hit[k]),
            .meta       (way_meta[k]),
            .rd_word    (way_word[k]),
            .rd_block   (way_block[k])
        );
    end

    ///////////////////////////////////////////////////////////////////////
    // replacement
    ///////////////////////////////////////////////////////////////////////

    // recency moves on a lookup hit or a fill
    victim_sel u_victim (
        .clk       (clk),
        .rst_n     (rst_n),
        .index     (index),
        .valid0    (way_meta[0].valid),
        .valid1    (way_meta[1].valid),
        .touch     ((lookup & hit) | fill),
        .touch_way (fill ? victim : hit_way),
        .victim    (victim)
    );

    ///////////////////////////////////////////////////////////////////////
    // merge and muxing
    ///////////////////////////////////////////////////////////////////////

    // at most one way hits, tags in a set are unique
    assign hit = |way_hit;

    always_comb begin
        hit_way = '0;
        for (int k = 0; k < `CACHE_WAYS; k++) begin
            if (way_hit[k]) begin
                hit_way = way_t'(k);
            end
        end
    end

    assign rd_word = way_word[hit_way];

    // victim side, feeds the miss decision and the write-back
    assign victim_valid = way_meta[victim].valid;
    assign victim_dirty = way_meta[victim].dirty;
    assign wb_block     = way_block[victim];
    assign wb_tag       = way_meta[victim].tag;

endmodule

//--- hw/cache_ctrl.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    // processor port
    input  logic                      cpu_req,
    input  cache_bus_pkg::cpu_req_t   cpu_req_in,
    output logic                      cpu_ready,
    output logic                      cpu_done,
    output cache_bus_pkg::cpu_rsp_t   cpu_rsp,
    // memory port
    output logic                      mem_req,
    output cache_bus_pkg::mem_req_t   mem_req_out,
    input  logic                      mem_ready,
    input  cache_line_pkg::block_t    mem_rdata,
    // array control
    output logic                      lookup,
    output logic                      wr_word,
    output logic                      fill,
    output cache_line_pkg::tag_t      tag,
    output cache_line_pkg::index_t    index,
    output cache_line_pkg::word_sel_t word_sel,
    output cache_line_pkg::byte_en_t  byte_en,
    output cache_line_pkg::word_t     wdata,
    output cache_line_pkg::block_t    fill_block,
    // array status
    input  logic                      hit,
    input  logic                      victim_dirty,
    input  logic                      victim_valid,
    input  cache_line_pkg::word_t     rd_word,
    input  cache_line_pkg::block_t    wb_block,
    input  cache_line_pkg::tag_t      wb_tag
);
    import cache_line_pkg::*;
    import cache_bus_pkg::*;

    // byte offset bits below the word select
    localparam int BYTE_W = $clog2(`CACHE_WORD_W / 8);

    ctrl_state_e state;
    ctrl_state_e state_nx;

    cpu_req_t req_q;
    block_t   fill_q;

    logic take_req;
    logic hit_done;
    logic start_wb;
    logic start_rf;
    logic rf_done;

    ///////////////////////////////////////////////////////////////////////
    // latched request, split into address fields
    ///////////////////////////////////////////////////////////////////////

    assign tag      = req_q.addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign index    = req_q.addr[BYTE_W+`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    assign word_sel = req_q.addr[BYTE_W +: `CACHE_OFFSET_W];
    assign byte_en  = req_q.byte_en;
    assign wdata    = req_q.wdata;

    // array modes follow the state directly
    assign lookup     = (state == LOOKUP);
    assign wr_word    = lookup & req_q.write;
    assign fill       = (state == FILL);
    assign fill_block = fill_q;

    // new requests only in idle
    assign cpu_ready = (state == IDLE);

    // transition events
    assign take_req = cpu_ready & cpu_req;
    assign hit_done = lookup & hit;
    assign start_wb = lookup & ~hit & victim_valid & victim_dirty;
    // clean or empty victim goes straight to refill, so does a finished write-back
    assign start_rf = (lookup & ~hit & ~(victim_valid & victim_dirty))
                    | ((state == WRITEBACK) & mem_ready);
    assign rf_done  = (state == REFILL) & mem_ready;

    ///////////////////////////////////////////////////////////////////////
    // FSM
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        state_nx = state;
        case (state)
            IDLE:      if (take_req) state_nx = LOOKUP;
            LOOKUP:    state_nx = hit ? IDLE : (start_wb ? WRITEBACK : REFILL);
            WRITEBACK: if (mem_ready) state_nx = REFILL;
            REFILL:    if (mem_ready) state_nx = FILL;
            // refilled line is looked up again and hits
            FILL:      state_nx = LOOKUP;
            default:   state_nx = IDLE;
        endcase
    end

    // state and the two pulses
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            cpu_done <= 1'b0;
            mem_req  <= 1'b0;
        end else begin
            state    <= state_nx;
            cpu_done <= hit_done;
            mem_req  <= start_wb | start_rf;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // payload registers
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (take_req) begin
            req_q <= cpu_req_in;
        end
        // old word on a write hit, the stored word on a read
        if (hit_done) begin
            cpu_rsp.rdata <= rd_word;
        end
        // held steady until mem_ready
        if (start_wb) begin
            mem_req_out <= '{write: 1'b1, tag: wb_tag, index: index, wblock: wb_block};
        end else if (start_rf) begin
            mem_req_out <= '{write: 1'b0, tag: tag, index: index, wblock: '0};
        end
        if (rf_done) begin
            fill_q <= mem_rdata;
        end
    end

endmodule

//--- hw/cache_top.sv
`timescale 1ns/1ps

module cache_top (
    input  logic                    clk,
    input  logic                    rst_n,
    // processor port
    input  logic                    cpu_req,
    input  cache_bus_pkg::cpu_req_t cpu_req_in,
    output logic                    cpu_ready,
    output logic                    cpu_done,
    output cache_bus_pkg::cpu_rsp_t cpu_rsp,
    // memory port
    output logic                    mem_req,
    output cache_bus_pkg::mem_req_t mem_req_out,
    input  logic                    mem_ready,
    input  cache_line_pkg::block_t  mem_rdata
);
    import cache_line_pkg::*;

    // controller to array
    logic      lookup;
    logic      wr_word;
    logic      fill;
    tag_t      tag;
    index_t    index;
    word_sel_t word_sel;
    byte_en_t  byte_en;
    word_t     wdata;
    block_t    fill_block;

    // array to controller
    logic      hit;
    logic      victim_dirty;
    logic      victim_valid;
    word_t     rd_word;
    block_t    wb_block;
    tag_t      wb_tag;

    cache_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .cpu_req(cpu_req), .cpu_req_in(cpu_req_in),
        .cpu_ready(cpu_ready), .cpu_done(cpu_done), .cpu_rsp(cpu_rsp),
        .mem_req(mem_req), .mem_req_out(mem_req_out),
        .mem_ready(mem_ready), .mem_rdata(mem_rdata),
        .lookup(lookup), .wr_word(wr_word), .fill(fill),
        .tag(tag), .index(index), .word_sel(word_sel),
        .byte_en(byte_en), .wdata(wdata), .fill_block(fill_block),
        .hit(hit), .victim_dirty(victim_dirty), .victim_valid(victim_valid),
        .rd_word(rd_word), .wb_block(wb_block), .wb_tag(wb_tag)
    );

    // hit way is only needed inside the array
    cache_set_assoc u_array (
        .clk(clk), .rst_n(rst_n),
        .lookup(lookup), .wr_word(wr_word), .fill(fill),
        .tag(tag), .index(index), .word_sel(word_sel),
        .byte_en(byte_en), .wdata(wdata), .fill_block(fill_block),
        .hit(hit), .hit_way(),
        .victim_dirty(victim_dirty), .victim_valid(victim_valid),
        .rd_word(rd_word), .wb_block(wb_block), .wb_tag(wb_tag)
    );

endmodule

//--- tb/cache_tb.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_tb;
    import cache_line_pkg::*;
    import cache_bus_pkg::*;

    localparam int SETS     = 1 << `CACHE_INDEX_W;
    localparam int WORDS    = 1 << `CACHE_OFFSET_W;
    localparam int BYTE_W   = 2;
    localparam int WAIT_MAX = 200;
    localparam int N_RANDOM = 400;

    // block address as memory sees it
    typedef logic [`CACHE_TAG_W+`CACHE_INDEX_W-1:0] blk_addr_t;

    logic     clk;
    logic     rst_n;
    logic     cpu_req;
    cpu_req_t cpu_req_in;
    logic     cpu_ready;
    logic     cpu_done;
    cpu_rsp_t cpu_rsp;
    logic     mem_req;
    mem_req_t mem_req_out;
    logic     mem_ready;
    block_t   mem_rdata;

    // backing memory where blocks appear on first touch
    block_t mem_blocks [blk_addr_t];

    // reference cache with two ways per set
    tag_t   ref_tag   [SETS][2];
    logic   ref_valid [SETS][2];
    logic   ref_dirty [SETS][2];
    block_t ref_data  [SETS][2];
    way_t   ref_lru   [SETS];

    // memory requests the model expects in order
    mem_req_t exp_mem [$];

    logic [31:0] rng_state;
    tag_t        tag_pool [4];

    int n_checks;
    int value_errors;
    int other_errors;

    cache_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpu_req     (cpu_req),
        .cpu_req_in  (cpu_req_in),
        .cpu_ready   (cpu_ready),
        .cpu_done    (cpu_done),
        .cpu_rsp     (cpu_rsp),
        .mem_req     (mem_req),
        .mem_req_out (mem_req_out),
        .mem_ready   (mem_ready),
        .mem_rdata   (mem_rdata)
    );

    // 20 ns clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // random numbers and memory contents
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // random fill on first use keyed by tag and index
    function automatic block_t mem_block(input tag_t t, input index_t ix);
        blk_addr_t a;
        block_t    b;
        a = {t, ix};
        if (!mem_blocks.exists(a)) begin
            b = '0;
            for (int w = 0; w < WORDS; w++) begin
                b[w*`CACHE_WORD_W +: `CACHE_WORD_W] = xorshift32();
            end
            mem_blocks[a] = b;
        end
        return mem_blocks[a];
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reporting
    //////////////////////////////////////////////////////////////////////

    task automatic finish_run();
        $display("checks %0d, value errors %0d, other errors %0d",
                 n_checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    task automatic other_error(input string what);
        other_errors++;
        $display("at %0t: %s", $time, what);
    endtask

    task automatic report_timeout(input string what);
        other_error({"timeout, ", what});
        finish_run();
    endtask

    function automatic string format_mem_req(input mem_req_t r);
        return $sformatf("write=%b tag=%h index=%h wblock=%h",
                         r.write, r.tag, r.index, r.wblock);
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        n_checks++;
        if (got !== exp) begin
            value_errors++;
            $display("ERROR %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_mem_req(input mem_req_t got, input mem_req_t exp);
        n_checks++;
        if (got !== exp) begin
            value_errors++;
            $display("ERROR %0t mem_req_out: got %s expected %s",
                     $time, format_mem_req(got), format_mem_req(exp));
        end
    endtask

    task automatic check_cycles(input string name, input int got, input int exp);
        n_checks++;
        if (got != exp) begin
            value_errors++;
            $display("ERROR %0t %s: got %0d cycles expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            value_errors++;
            $display("ERROR %0t %s: got %b expected %b", $time, name, got, exp);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    // applies one access and queues the memory traffic it implies
    task automatic predict(input cpu_req_t rq, output word_t exp_rd, output logic exp_hit);
        tag_t      t;
        index_t    ix;
        word_sel_t ws;
        way_t      w;
        word_t     cur;
        mem_req_t  mr;
        t  = rq.addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
        ix = rq.addr[BYTE_W+`CACHE_OFFSET_W +: `CACHE_INDEX_W];
        ws = rq.addr[BYTE_W +: `CACHE_OFFSET_W];
        exp_hit = 1'b0;
        w = '0;
        for (int k = 0; k < 2; k++) begin
            if (ref_valid[ix][k] && ref_tag[ix][k] == t) begin
                exp_hit = 1'b1;
                w = way_t'(k);
            end
        end
        if (!exp_hit) begin
            // empty way first or else least recently used
            if (!ref_valid[ix][0]) begin
                w = 1'b0;
            end else if (!ref_valid[ix][1]) begin
                w = 1'b1;
            end else begin
                w = ref_lru[ix];
            end
            // dirty victim goes out before the refill
            if (ref_valid[ix][w] && ref_dirty[ix][w]) begin
                mr = '{write: 1'b1, tag: ref_tag[ix][w], index: ix, wblock: ref_data[ix][w]};
                exp_mem.push_back(mr);
            end
            mr = '{write: 1'b0, tag: t, index: ix, wblock: '0};
            exp_mem.push_back(mr);
            ref_data[ix][w]  = mem_block(t, ix);
            ref_tag[ix][w]   = t;
            ref_valid[ix][w] = 1'b1;
            ref_dirty[ix][w] = 1'b0;
        end
        // the used way is now most recent
        ref_lru[ix] = ~w;
        cur = ref_data[ix][w][int'(ws)*`CACHE_WORD_W +: `CACHE_WORD_W];
        exp_rd = cur;
        if (rq.write) begin
            for (int b = 0; b < `CACHE_WORD_W/8; b++) begin
                if (rq.byte_en[b]) begin
                    cur[b*8 +: 8] = rq.wdata[b*8 +: 8];
                end
            end
            ref_data[ix][w][int'(ws)*`CACHE_WORD_W +: `CACHE_WORD_W] = cur;
            ref_dirty[ix][w] = 1'b1;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // bus driving
    //////////////////////////////////////////////////////////////////////

    // one memory transaction with 1 to 8 cycles of delay
    task automatic serve_mem();
        mem_req_t  got;
        mem_req_t  exp;
        blk_addr_t a;
        int        d;
        got = mem_req_out;
        if (exp_mem.size() == 0) begin
            other_error("memory request while the model expects none");
        end else begin
            exp = exp_mem.pop_front();
            check_mem_req(got, exp);
        end
        d = 1 + int'(xorshift32() % 8);
        for (int i = 1; i < d; i++) begin
            @(negedge clk);
            if (cpu_ready) begin
                other_error("cpu_ready high while waiting on memory");
            end
        end
        a = {got.tag, got.index};
        if (got.write) begin
            mem_blocks[a] = got.wblock;
        end
        @(posedge clk);
        mem_ready <= 1'b1;
        mem_rdata <= got.write ? '0 : mem_block(got.tag, got.index);
        @(posedge clk);
        mem_ready <= 1'b0;
    endtask

    // issue one request and serve memory until cpu_done
    task automatic run_access(input cpu_req_t rq, output word_t rd, output int lat);
        int   t;
        logic done;
        t = 0;
        while (!cpu_ready) begin
            @(negedge clk);
            t++;
            if (t > WAIT_MAX) begin
                report_timeout("cpu_ready never rose");
            end
        end
        @(posedge clk);
        cpu_req    <= 1'b1;
        cpu_req_in <= rq;
        // request is sampled on this edge
        @(posedge clk);
        cpu_req <= 1'b0;
        lat  = 0;
        done = 1'b0;
        rd   = '0;
        while (!done) begin
            @(negedge clk);
            lat++;
            if (lat > WAIT_MAX) begin
                report_timeout("cpu_done never came");
            end else if (cpu_done) begin
                rd   = cpu_rsp.rdata;
                done = 1'b1;
            end else begin
                if (cpu_ready) begin
                    other_error("cpu_ready high before cpu_done");
                end
                if (mem_req) begin
                    serve_mem();
                end
            end
        end
    endtask

    // one access checked against the model
    task automatic access(input logic wr, input tag_t t, input index_t ix,
                          input word_sel_t ws, input byte_en_t be, input word_t wd);
        cpu_req_t rq;
        word_t    exp_rd;
        word_t    got_rd;
        logic     exp_hit;
        int       lat;
        rq = '{write: wr, addr: {t, ix, ws, 2'b00}, wdata: wd, byte_en: be};
        predict(rq, exp_rd, exp_hit);
        run_access(rq, got_rd, lat);
        if (!wr) begin
            check_word("cpu_rsp.rdata", got_rd, exp_rd);
        end
        // hit answers in the second cycle after the sampling edge
        if (exp_hit) begin
            check_cycles("cpu_done latency", lat, 2);
        end
        if (exp_mem.size() != 0) begin
            other_error("expected memory request never issued");
            exp_mem.delete();
        end
    endtask

    // few tags over few sets give plenty of evictions
    task automatic random_run();
        logic [31:0] r;
        for (int n = 0; n < N_RANDOM; n++) begin
            r = xorshift32();
            access(r[0], tag_pool[r[2:1]], index_t'(r[6:3]), word_sel_t'(r[9:7]),
                   byte_en_t'(r[13:10]), xorshift32());
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        rng_state    = 32'hde3;
        n_checks     = 0;
        value_errors = 0;
        other_errors = 0;
        rst_n        = 1'b0;
        cpu_req      = 1'b0;
        cpu_req_in   = '0;
        mem_ready    = 1'b0;
        mem_rdata    = '0;
        for (int s = 0; s < SETS; s++) begin
            ref_lru[s] = 1'b0;
            for (int k = 0; k < 2; k++) begin
                ref_valid[s][k] = 1'b0;
                ref_dirty[s][k] = 1'b0;
                ref_tag[s][k]   = '0;
                ref_data[s][k]  = '0;
            end
        end
        // low bits keep the pool distinct
        for (int k = 0; k < 4; k++) begin
            r = xorshift32();
            tag_pool[k] = {r[`CACHE_TAG_W-1:2], 2'(k)};
        end

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_bit("cpu_ready", cpu_ready, 1'b1);
        check_bit("cpu_done", cpu_done, 1'b0);
        check_bit("mem_req", mem_req, 1'b0);

        // cold read with exactly one block read
        access(1'b0, tag_pool[0], 6'd5, 3'd3, 4'h0, '0);
        // write hit with partial bytes then read back
        access(1'b1, tag_pool[0], 6'd5, 3'd3, 4'b0101, xorshift32());
        access(1'b0, tag_pool[0], 6'd5, 3'd3, 4'h0, '0);
        // clean read hit without memory traffic
        access(1'b0, tag_pool[0], 6'd5, 3'd6, 4'h0, '0);

        // third tag in set 9 pushes out the dirty least recent line
        access(1'b1, tag_pool[0], 6'd9, 3'd0, 4'hf, xorshift32());
        access(1'b1, tag_pool[1], 6'd9, 3'd1, 4'hf, xorshift32());
        access(1'b1, tag_pool[2], 6'd9, 3'd2, 4'b1000, xorshift32());
        // tag 1 is now least recent
        access(1'b0, tag_pool[0], 6'd9, 3'd0, 4'h0, '0);
        access(1'b0, tag_pool[2], 6'd9, 3'd2, 4'h0, '0);
        access(1'b0, tag_pool[1], 6'd9, 3'd1, 4'h0, '0);

        // in set 12 an empty way is taken before any eviction
        access(1'b0, tag_pool[0], 6'd12, 3'd4, 4'h0, '0);
        access(1'b0, tag_pool[1], 6'd12, 3'd5, 4'h0, '0);
        access(1'b0, tag_pool[0], 6'd12, 3'd4, 4'h0, '0);
        access(1'b0, tag_pool[2], 6'd12, 3'd7, 4'h0, '0);
        access(1'b0, tag_pool[0], 6'd12, 3'd4, 4'h0, '0);
        access(1'b0, tag_pool[1], 6'd12, 3'd5, 4'h0, '0);

        random_run();
        finish_run();
    end

endmodule

//--- compile.f
+incdir+hw
hw/cache_line_pkg.sv
hw/cache_bus_pkg.sv
hw/cache_way.sv
hw/victim_sel.sv
hw/cache_set_assoc.sv
hw/cache_ctrl.sv
hw/cache_top.sv
tb/cache_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module cache_tb \
    -Mdir "$BUILD_DIR" -f compile.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/Vcache_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0
